/* axi_rd_demux.f */
+incdir+hw
hw/axi_rd_pkg.sv
hw/demux_pkg.sv
hw/ar_spill_reg.sv
hw/id_inflight_table.sv
hw/ar_route.sv
hw/r_rr_mux.sv
hw/axi_rd_demux.sv
tb/tb_axi_rd_demux.sv

/* run.sh */
#!/bin/sh
# build and run the read demux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f axi_rd_demux.f \
  --top-module tb_axi_rd_demux \
  -Mdir obj_dir -o sim_tb

# the simulator exits non-zero on a fatal check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* tb/tb_axi_rd_demux.sv */
// read demux testbench
`timescale 1ns/10ps
`include "demux_defines.svh"

module tb_axi_rd_demux;

  localparam int unsigned NUM_REQ  = 48;
  localparam int unsigned MAX_LEN  = 7;
  localparam int unsigned NUM_MST  = `DMX_NUM_MST;
  localparam int unsigned NUM_LOOK = 2 ** `DMX_LOOK_BITS;
  // cycles per beat for stalls and ordering waits
  localparam int unsigned MARGIN   = 16;
  localparam int unsigned TIMEOUT_CYC = NUM_REQ * (MAX_LEN + 1) * MARGIN + 100;

  logic                                   clk_i;
  logic                                   rst_ni;
  axi_rd_pkg::ar_chan_t                   slv_ar;
  demux_pkg::sel_t                        slv_ar_sel;
  logic                                   slv_ar_valid;
  logic                                   slv_ar_ready;
  axi_rd_pkg::r_chan_t                    slv_r;
  logic                                   slv_r_valid;
  logic                                   slv_r_ready;
  axi_rd_pkg::ar_chan_t                   mst_ar;
  logic [NUM_MST-1:0]                     mst_ar_valid;
  logic [NUM_MST-1:0]                     mst_ar_ready;
  axi_rd_pkg::r_chan_t [NUM_MST-1:0]      mst_r;
  logic [NUM_MST-1:0]                     mst_r_valid;
  logic [NUM_MST-1:0]                     mst_r_ready;

  // request table built once from the random stream
  axi_rd_pkg::ar_chan_t req_ar [NUM_REQ];
  demux_pkg::sel_t      req_sel [NUM_REQ];

  logic [31:0] rng;
  // next request offered at the slave ar
  int unsigned ar_idx;
  // accepted at the slave but not yet at a master
  int unsigned pend_q [$];
  // bursts each master model still has to answer
  int unsigned mq [NUM_MST][$];
  int unsigned drv_beat [NUM_MST];
  // checker view of owed bursts per port
  int unsigned eq [NUM_MST][$];
  int unsigned outst [NUM_LOOK][NUM_MST];
  int unsigned done_cnt;
  bit          cur_busy;
  int unsigned cur_port;
  int unsigned cur_beat;
  // handshakes seen at the last sample point
  bit                 ar_fire;
  logic [NUM_MST-1:0] r_fire_mst;

  axi_rd_demux uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_ar_i       (slv_ar),
    .slv_ar_sel_i   (slv_ar_sel),
    .slv_ar_valid_i (slv_ar_valid),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid),
    .slv_r_ready_i  (slv_r_ready),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_i        (mst_r),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // true num times out of den
  function automatic bit chance(input int unsigned num, input int unsigned den);
    return (next_rand() % den) < num;
  endfunction

  // expected beat data from address and beat index
  function automatic logic [31:0] ref_data(input logic [31:0] addr, input int unsigned beat);
    logic [31:0] b;
    b = beat;
    return (addr + (b << 2)) ^ {b[7:0], 24'h3c5a96};
  endfunction

  function automatic bit drained();
    bit ok;
    ok = (ar_idx == NUM_REQ) && (pend_q.size() == 0) && !cur_busy;
    for (int p = 0; p < NUM_MST; p++) begin
      ok = ok && (eq[p].size() == 0) && (mq[p].size() == 0);
      for (int l = 0; l < NUM_LOOK; l++) begin
        ok = ok && (outst[l][p] == 0);
      end
    end
    return ok && !slv_r_valid && (mst_ar_valid == '0);
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stop_with_error($sformatf("error %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus applied on the falling edge
  // --------------------------------------------------------------------------
  task automatic drive_slave_ar();
    if (ar_fire) begin
      slv_ar_valid = 1'b0;
      ar_idx++;
    end
    // hold valid and payload until taken
    if (!slv_ar_valid && (ar_idx < NUM_REQ) && chance(3, 4)) begin
      slv_ar       = req_ar[ar_idx];
      slv_ar_sel   = req_sel[ar_idx];
      slv_ar_valid = 1'b1;
    end
    slv_r_ready = chance(3, 4);
  endtask

  task automatic answer_masters();
    int unsigned idx;
    for (int p = 0; p < NUM_MST; p++) begin
      mst_ar_ready[p] = chance(1, 2);
      if (r_fire_mst[p]) begin
        idx = mq[p][0];
        if (drv_beat[p] == 32'(req_ar[idx].len)) begin
          void'(mq[p].pop_front());
          drv_beat[p] = 0;
        end else begin
          drv_beat[p]++;
        end
      end
      // in-order answer of the oldest accepted ar
      if (mq[p].size() > 0) begin
        idx = mq[p][0];
        mst_r[p].id    = req_ar[idx].id;
        mst_r[p].data  = ref_data(req_ar[idx].addr, drv_beat[p]);
        mst_r[p].last  = (drv_beat[p] == 32'(req_ar[idx].len));
        mst_r_valid[p] = 1'b1;
      end else begin
        mst_r[p]       = '0;
        mst_r_valid[p] = 1'b0;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // monitors sampled mid low phase where all inputs have settled
  // --------------------------------------------------------------------------
  task automatic watch_ar_channels();
    int unsigned              idx;
    logic [`DMX_LOOK_BITS-1:0] look;
    if ($countones(mst_ar_valid) > 1) begin
      stop_with_error("more than one master ar valid is high at once");
    end
    for (int p = 0; p < NUM_MST; p++) begin
      if (mst_ar_valid[p] && mst_ar_ready[p]) begin
        if (pend_q.size() == 0) begin
          stop_with_error($sformatf("master %0d took an ar that was never issued", p));
        end
        idx = pend_q.pop_front();
        check_eq($sformatf("ar port req %0d", idx), 64'(req_sel[idx]), 64'(p));
        check_eq($sformatf("ar id req %0d", idx), 64'(req_ar[idx].id), 64'(mst_ar.id));
        check_eq($sformatf("ar addr req %0d", idx), 64'(req_ar[idx].addr), 64'(mst_ar.addr));
        check_eq($sformatf("ar len req %0d", idx), 64'(req_ar[idx].len), 64'(mst_ar.len));
        // same low id bits must not be owed elsewhere
        look = req_ar[idx].id[`DMX_LOOK_BITS-1:0];
        for (int q = 0; q < NUM_MST; q++) begin
          if (q != p) begin
            check_eq($sformatf("order req %0d owed at port %0d", idx, q), 64'(0),
                     64'(outst[look][q]));
          end
        end
        outst[look][p]++;
        mq[p].push_back(idx);
        eq[p].push_back(idx);
      end
    end
    ar_fire = slv_ar_valid && slv_ar_ready;
    if (ar_fire) begin
      pend_q.push_back(ar_idx);
    end
  endtask

  task automatic watch_r_channel();
    int unsigned              idx;
    bit                       found;
    logic [`DMX_LOOK_BITS-1:0] look;
    r_fire_mst = mst_r_valid & mst_r_ready;
    if (slv_r_valid && slv_r_ready) begin
      if (!cur_busy) begin
        // new burst from the port owing this id at its head
        found = 1'b0;
        for (int q = 0; q < NUM_MST; q++) begin
          if (!found && (eq[q].size() > 0) && (req_ar[eq[q][0]].id == slv_r.id)) begin
            found    = 1'b1;
            cur_port = q;
          end
        end
        if (!found) begin
          stop_with_error($sformatf("slave r beat with id %0h that no port owes", slv_r.id));
        end
        cur_busy = 1'b1;
        cur_beat = 0;
      end
      idx = eq[cur_port][0];
      // beat must come from the locked port and no other
      check_eq($sformatf("r grant req %0d", idx), 64'(1) << cur_port, 64'(r_fire_mst));
      check_eq($sformatf("r id req %0d", idx), 64'(req_ar[idx].id), 64'(slv_r.id));
      check_eq($sformatf("r data req %0d beat %0d", idx, cur_beat),
               64'(ref_data(req_ar[idx].addr, cur_beat)), 64'(slv_r.data));
      check_eq($sformatf("r last req %0d beat %0d", idx, cur_beat),
               64'(cur_beat == 32'(req_ar[idx].len)), 64'(slv_r.last));
      if (cur_beat == 32'(req_ar[idx].len)) begin
        void'(eq[cur_port].pop_front());
        look = req_ar[idx].id[`DMX_LOOK_BITS-1:0];
        outst[look][cur_port]--;
        done_cnt++;
        cur_busy = 1'b0;
      end else begin
        cur_beat++;
      end
    end else begin
      // a master beat only moves together with a slave beat
      check_eq("r master beat without slave beat", 64'(0), 64'(r_fire_mst));
    end
  endtask

  // --------------------------------------------------------------------------
  // processes
  // --------------------------------------------------------------------------
  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #5;
      clk_i = ~clk_i;
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] a;
    rst_ni       = 1'b0;
    slv_ar       = '0;
    slv_ar_sel   = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready  = 1'b0;
    mst_ar_ready = '0;
    mst_r        = '0;
    mst_r_valid  = '0;
    ar_idx       = 0;
    done_cnt     = 0;
    cur_busy     = 1'b0;
    cur_port     = 0;
    cur_beat     = 0;
    ar_fire      = 1'b0;
    r_fire_mst   = '0;
    rng          = 32'h3db4145c;
    for (int p = 0; p < NUM_MST; p++) begin
      drv_beat[p] = 0;
      for (int l = 0; l < NUM_LOOK; l++) begin
        outst[l][p] = 0;
      end
    end
    // ids 0, 1, 8, 9 so low bits collide often
    for (int i = 0; i < NUM_REQ; i++) begin
      r = next_rand();
      a = next_rand();
      req_ar[i].id   = {r[3], 2'b00, r[0]};
      req_ar[i].addr = {a[31:6], 6'h00};
      req_ar[i].len  = 8'(r[10:8]);
      req_sel[i]     = demux_pkg::sel_t'(r[23:16] % 8'(NUM_MST));
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    forever begin
      @(negedge clk_i);
      drive_slave_ar();
      answer_masters();
    end
  end

  initial begin : scoreboard
    wait (rst_ni === 1'b1);
    while (done_cnt < NUM_REQ) begin
      @(negedge clk_i);
      #2;
      watch_ar_channels();
      watch_r_channel();
    end
    @(negedge clk_i);
    #2;
    if (drained()) begin
      $display("TEST PASS");
      $finish;
    end else begin
      stop_with_error("requests or bursts left over after all bursts returned");
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    stop_with_error($sformatf("timeout after %0d cycles with %0d of %0d bursts done",
                              TIMEOUT_CYC, done_cnt, NUM_REQ));
  end

endmodule

/* hw/axi_rd_demux.sv */
// axi read demux top level
`timescale 1ns/10ps
`include "demux_defines.svh"

module axi_rd_demux (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // slave ar
  input  axi_rd_pkg::ar_chan_t                    slv_ar_i,
  input  demux_pkg::sel_t                         slv_ar_sel_i,
  input  logic                                    slv_ar_valid_i,
  output logic                                    slv_ar_ready_o,
  // slave r
  output axi_rd_pkg::r_chan_t                     slv_r_o,
  output logic                                    slv_r_valid_o,
  input  logic                                    slv_r_ready_i,
  // master ar, payload shared by all ports
  output axi_rd_pkg::ar_chan_t                    mst_ar_o,
  output logic [`DMX_NUM_MST-1:0]                 mst_ar_valid_o,
  input  logic [`DMX_NUM_MST-1:0]                 mst_ar_ready_i,
  // master r
  input  axi_rd_pkg::r_chan_t [`DMX_NUM_MST-1:0] mst_r_i,
  input  logic [`DMX_NUM_MST-1:0]                 mst_r_valid_i,
  output logic [`DMX_NUM_MST-1:0]                 mst_r_ready_o
);

  // ------------------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------------------
  demux_pkg::ar_req_t  slv_req;
  demux_pkg::ar_req_t  sp_req;
  logic                sp_valid, sp_ready;
  demux_pkg::look_id_t look_id;
  demux_pkg::look_id_t pop_id;
  demux_pkg::sel_t     lookup_sel;
  logic                lookup_busy, cnt_full;
  logic                ar_push, r_pop;

  assign slv_req.ar  = slv_ar_i;
  assign slv_req.sel = slv_ar_sel_i;

  // ordering uses the low id bits only
  assign look_id = sp_req.ar.id[`DMX_LOOK_BITS-1:0];
  assign pop_id  = slv_r_o.id[`DMX_LOOK_BITS-1:0];

  // ar input buffer
  ar_spill_reg i_ar_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (slv_ar_valid_i),
    .ready_o (slv_ar_ready_o),
    .data_i  (slv_req),
    .valid_o (sp_valid),
    .ready_i (sp_ready),
    .data_o  (sp_req)
  );

  // ordering check and steering
  ar_route i_ar_route (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (sp_req),
    .valid_i       (sp_valid),
    .ready_o       (sp_ready),
    .mst_ar_o      (mst_ar_o),
    .mst_valid_o   (mst_ar_valid_o),
    .mst_ready_i   (mst_ar_ready_i),
    .lookup_sel_i  (lookup_sel),
    .lookup_busy_i (lookup_busy),
    .full_i        (cnt_full),
    .push_o        (ar_push)
  );

  // outstanding bursts per id
  id_inflight_table i_id_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (look_id),
    .lookup_sel_o  (lookup_sel),
    .lookup_busy_o (lookup_busy),
    .full_o        (cnt_full),
    .push_i        (ar_push),
    .push_id_i     (look_id),
    .push_sel_i    (sp_req.sel),
    .pop_i         (r_pop),
    .pop_id_i      (pop_id)
  );

  // r burst merge
  r_rr_mux i_r_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mst_r_i     (mst_r_i),
    .mst_valid_i (mst_r_valid_i),
    .mst_ready_o (mst_r_ready_o),
    .slv_r_o     (slv_r_o),
    .slv_valid_o (slv_r_valid_o),
    .slv_ready_i (slv_r_ready_i),
    .pop_o       (r_pop)
  );

endmodule

/* hw/r_rr_mux.sv */
// round-robin r burst arbiter
`timescale 1ns/10ps
`include "demux_defines.svh"

module r_rr_mux (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // master r ports
  input  axi_rd_pkg::r_chan_t [`DMX_NUM_MST-1:0] mst_r_i,
  input  logic [`DMX_NUM_MST-1:0]                 mst_valid_i,
  output logic [`DMX_NUM_MST-1:0]                 mst_ready_o,
  // slave r port
  output axi_rd_pkg::r_chan_t                     slv_r_o,
  output logic                                    slv_valid_o,
  input  logic                                    slv_ready_i,
  // last beat handed over
  output logic                                    pop_o
);

  // port with top priority when unlocked
  demux_pkg::sel_t prio_q;
  // burst in progress and its owner
  logic            lock_q;
  demux_pkg::sel_t lock_idx_q;

  demux_pkg::sel_t pick_idx;
  demux_pkg::sel_t gnt_idx;
  logic            last_xfer;

  // ------------------------------------------------------------------------
  // rotating priority search
  // ------------------------------------------------------------------------
  always_comb begin : proc_pick
    demux_pkg::sel_t cand;
    logic            found;
    found    = 1'b0;
    cand     = prio_q;
    pick_idx = prio_q;
    for (int k = 0; k < `DMX_NUM_MST; k++) begin
      cand = demux_pkg::sel_t'((int'(prio_q) + k) % `DMX_NUM_MST);
      if (!found && mst_valid_i[cand]) begin
        found    = 1'b1;
        pick_idx = cand;
      end
    end
  end

  // locked owner wins over the search
  assign gnt_idx = lock_q ? lock_idx_q : pick_idx;

  // ------------------------------------------------------------------------
  // data path, zero cycles
  // ------------------------------------------------------------------------
  assign slv_valid_o = mst_valid_i[gnt_idx];
  assign slv_r_o     = mst_r_i[gnt_idx];

  always_comb begin
    for (int i = 0; i < `DMX_NUM_MST; i++) begin
      mst_ready_o[i] = slv_ready_i && (gnt_idx == demux_pkg::sel_t'(i));
    end
  end

  assign last_xfer = slv_valid_o && slv_ready_i && slv_r_o.last;
  assign pop_o     = last_xfer;

  // ------------------------------------------------------------------------
  // grant lock and priority update
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      if (last_xfer) begin
        // burst done, next port gets first pick
        lock_q <= 1'b0;
        if (gnt_idx == demux_pkg::sel_t'(`DMX_NUM_MST - 1)) begin
          prio_q <= '0;
        end else begin
          prio_q <= gnt_idx + demux_pkg::sel_t'(1);
        end
      end else if (slv_valid_o) begin
        // stalled or mid-burst, keep the owner
        lock_q     <= 1'b1;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

/* hw/ar_route.sv */
// ar ordering check and port steering
`timescale 1ns/10ps
`include "demux_defines.svh"

module ar_route (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // request from the spill register
  input  demux_pkg::ar_req_t          req_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  // master ar ports
  output axi_rd_pkg::ar_chan_t        mst_ar_o,
  output logic [`DMX_NUM_MST-1:0]     mst_valid_o,
  input  logic [`DMX_NUM_MST-1:0]     mst_ready_i,
  // id table lookup
  input  demux_pkg::sel_t             lookup_sel_i,
  input  logic                        lookup_busy_i,
  input  logic                        full_i,
  // count the ar once it is taken
  output logic                        push_o
);

  demux_pkg::route_state_e state_q, state_d;
  logic                    order_ok;
  logic                    fwd_valid;
  logic                    sel_ready;

  // ------------------------------------------------------------------------
  // ordering decision
  // ------------------------------------------------------------------------
  // same id may only go where its earlier bursts went
  assign order_ok = !full_i && (!lookup_busy_i || (lookup_sel_i == req_i.sel));

  // ------------------------------------------------------------------------
  // one-hot steering
  // ------------------------------------------------------------------------
  // payload is common to every port
  assign mst_ar_o = req_i.ar;

  always_comb begin
    for (int i = 0; i < `DMX_NUM_MST; i++) begin
      mst_valid_o[i] = fwd_valid && (req_i.sel == demux_pkg::sel_t'(i));
    end
  end

  // ready of the selected port only
  assign sel_ready = |(mst_valid_o & mst_ready_i);

  // ------------------------------------------------------------------------
  // valid lock fsm
  // ------------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    fwd_valid = 1'b0;
    ready_o   = 1'b0;
    push_o    = 1'b0;
    case (state_q)
      demux_pkg::ROUTE_IDLE: begin
        if (valid_i && order_ok) begin
          fwd_valid = 1'b1;
          if (sel_ready) begin
            ready_o = 1'b1;
            push_o  = 1'b1;
          end else begin
            // hold the decision, table may change meanwhile
            state_d = demux_pkg::ROUTE_LOCKED;
          end
        end
      end
      demux_pkg::ROUTE_LOCKED: begin
        // checks already passed, only wait for ready
        fwd_valid = 1'b1;
        if (sel_ready) begin
          ready_o = 1'b1;
          push_o  = 1'b1;
          state_d = demux_pkg::ROUTE_IDLE;
        end
      end
      default: begin
        state_d = demux_pkg::ROUTE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= demux_pkg::ROUTE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // axi rule on the master side
  mst_valid_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((|mst_valid_o) && !sel_ready) |=> (mst_valid_o == $past(mst_valid_o))
  ) else $error("ar_route: master ar valid dropped without ready");

endmodule

/* hw/id_inflight_table.sv */
// per-id in-flight counter table
`timescale 1ns/10ps
`include "demux_defines.svh"

module id_inflight_table (
  input  logic                clk_i,
  input  logic                rst_ni,
  // lookup for the waiting ar
  input  demux_pkg::look_id_t lookup_id_i,
  output demux_pkg::sel_t     lookup_sel_o,
  output logic                lookup_busy_o,
  output logic                full_o,
  // ar sent to a master
  input  logic                push_i,
  input  demux_pkg::look_id_t push_id_i,
  input  demux_pkg::sel_t     push_sel_i,
  // last r beat sent to the slave
  input  logic                pop_i,
  input  demux_pkg::look_id_t pop_id_i
);

  localparam int unsigned NUM_CNT = 2 ** `DMX_LOOK_BITS;

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------
  demux_pkg::cnt_t [NUM_CNT-1:0] cnt_q;
  // port each id was last sent to
  demux_pkg::sel_t [NUM_CNT-1:0] sel_q;

  logic [NUM_CNT-1:0] push_en;
  logic [NUM_CNT-1:0] pop_en;
  logic [NUM_CNT-1:0] busy;
  logic [NUM_CNT-1:0] cnt_full;

  // one-hot decode of push and pop ids and flags per counter
  always_comb begin
    for (int i = 0; i < NUM_CNT; i++) begin
      push_en[i]  = push_i && (push_id_i == demux_pkg::look_id_t'(i));
      pop_en[i]   = pop_i && (pop_id_i == demux_pkg::look_id_t'(i));
      busy[i]     = |cnt_q[i];
      cnt_full[i] = &cnt_q[i];
    end
  end

  // ------------------------------------------------------------------------
  // lookup without delay
  // ------------------------------------------------------------------------
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = busy[lookup_id_i];
  // any full counter stops all new ars
  assign full_o        = |cnt_full;

  // ------------------------------------------------------------------------
  // counters
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        // push and pop together leave the count alone
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + demux_pkg::cnt_t'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - demux_pkg::cnt_t'(1);
        end
      end
    end
  end

  // record the target port on each push
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_CNT; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

  // every last beat must match an earlier ar of the same id
  no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> busy[pop_id_i]
  ) else $error("id_inflight_table: pop on idle id %0d", pop_id_i);

endmodule

/* hw/ar_spill_reg.sv */
// ar request spill register
`timescale 1ns/10ps

module ar_spill_reg (
  input  logic               clk_i,
  input  logic               rst_ni,
  // upstream side
  input  logic               valid_i,
  output logic               ready_o,
  input  demux_pkg::ar_req_t data_i,
  // downstream side
  output logic               valid_o,
  input  logic               ready_i,
  output demux_pkg::ar_req_t data_o
);

  // ------------------------------------------------------------------------
  // slot a takes new data, slot b holds what could not leave
  // ------------------------------------------------------------------------
  logic               a_full_q, b_full_q;
  demux_pkg::ar_req_t a_data_q, b_data_q;
  logic               a_fill, a_drain;
  logic               b_fill, b_drain;

  // accept while any slot is free
  assign a_fill  = valid_i && ready_o;
  // a moves on whenever b is not blocking it
  assign a_drain = a_full_q && !b_full_q;
  // a stalled downstream, park it in b
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // ------------------------------------------------------------------------
  // outputs, all from flops
  // ------------------------------------------------------------------------
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  // b is older than a
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // offered request must not change before it is taken
  a_data_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (valid_o && (data_o == $past(data_o)))
  ) else $error("ar_spill_reg: output changed while stalled");

endmodule

/* hw/demux_pkg.sv */
// demux control types
`include "demux_defines.svh"

package demux_pkg;

  // master port index
  typedef logic [`DMX_SEL_W-1:0] sel_t;

  // low id bits that pick an ordering counter
  typedef logic [`DMX_LOOK_BITS-1:0] look_id_t;

  // outstanding bursts per lookup id
  typedef logic [`DMX_CNT_W-1:0] cnt_t;

  // ar payload with its routing target
  typedef struct packed {
    axi_rd_pkg::ar_chan_t ar;
    sel_t                 sel;
  } ar_req_t;

  // ar valid lock
  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_LOCKED
  } route_state_e;

endpackage

/* hw/axi_rd_pkg.sv */
// axi read channel types
`include "demux_defines.svh"

package axi_rd_pkg;

  // ------------------------------------------------------------------------
  // field types
  // ------------------------------------------------------------------------
  typedef logic [`DMX_ID_W-1:0]   id_t;
  typedef logic [`DMX_ADDR_W-1:0] addr_t;
  typedef logic [`DMX_DATA_W-1:0] data_t;
  // beats minus one
  typedef logic [`DMX_LEN_W-1:0]  len_t;

  // ------------------------------------------------------------------------
  // channel payloads
  // ------------------------------------------------------------------------
  // read address, 44 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // read data beat, 37 bits
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

endpackage

/* hw/demux_defines.svh */
// read demux global sizes
`ifndef DEMUX_DEFINES_SVH
`define DEMUX_DEFINES_SVH

// number of master ports behind the demux
`define DMX_NUM_MST 3
// port select width, enough for DMX_NUM_MST
`define DMX_SEL_W 2

// axi channel field widths
`define DMX_ID_W 4
`define DMX_ADDR_W 32
`define DMX_DATA_W 32
`define DMX_LEN_W 8

// low id bits with an in-flight counter, 2**3 counters
`define DMX_LOOK_BITS 3
// counter width, all ones means full
`define DMX_CNT_W 3

`endif
